//--- tb/llm_int_stim.txt
# W lines hold one weight row in hex, element 0 first.
# X lines hold the input vector, the out_ready stall cycles and the expected output vector.
# First matrix.
W 0100 0200 0300 0400
W ff00 0100 fe00 0080
W 7fff 7fff 7fff 7fff
W 8000 8000 8000 8000
# All activations below the threshold, reduced path only.
X 0005 fffb 0003 fffe 0 fa00 ff00 8000 7fff
# One outlier at index 0.
X 0100 0002 fffd 0001 3 fe00 0100 00ff 0000
# Three above the threshold, index 2 loses its slot.
X 0010 0020 0030 0004 1 0050 0010 17ff e800
# Two outliers with a quantized remainder, rows 2 and 3 saturate.
X fff0 fffc 1234 0002 2 348c daa8 7fff 8000
# Second matrix replaces the first.
W 0200 0000 0000 0000
W 0000 0200 0000 0000
W 1000 1000 1000 1000
W 0001 0001 0001 0001
# Same input as before, new results.
X 0100 0002 fffd 0001 0 0200 0000 0000 0001
# Full-scale inputs, clipping both ways.
X 7fff 8000 7fff 8000 4 7fff 8000 eff0 ffff

//--- flist.f
src/llm_int_pkg.sv
src/outlier_scatter.sv
src/weight_store.sv
src/dual_precision_dot.sv
src/result_gather.sv
src/linear_ctrl.sv
src/llm_int_linear.sv
tb/tb_llm_int.sv

//--- Makefile
TOP := tb_llm_int
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir $(OBJ) -f flist.f

run: compile
	./$(OBJ)/V$(TOP) > sim.log 2>&1 || echo ">>> FAIL" >> sim.log
	cat sim.log
	@if grep -q ">>> FAIL" sim.log; then \
		echo "Simulation failed"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ) sim.log

//--- tb/tb_llm_int.sv
`timescale 1ns/1ps

module tb_llm_int;

    localparam int N = 4;

    typedef llm_int_pkg::act_t [N-1:0] vec_t;

    logic clk;
    logic arst_n;
    logic weight_valid;
    logic weight_ready;
    vec_t weight_row;
    logic in_valid;
    logic in_ready;
    vec_t in_data;
    logic out_valid;
    logic out_ready;
    vec_t out_data;

    bit   rec_is_input[$];  // 0 for a weight row, 1 for an input vector.
    vec_t rec_vec[$];
    int   rec_stall[$];
    vec_t rec_exp[$];

    int          value_errors;
    int          other_errors;
    int          n_vectors;
    int          w_idx;         // Next weight row of the matrix being loaded.
    logic        matrix_whole;  // All N rows of the current matrix loaded.
    logic        stim_loaded;
    logic [31:0] rng;

    llm_int_linear DUT (
        .clk, .arst_n, .weight_valid, .weight_ready, .weight_row,
        .in_valid, .in_ready, .in_data, .out_valid, .out_ready, .out_data
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic read_vec(input int fd, output vec_t v);
        logic [15:0] val;
        int          code;
        for (int i = 0; i < N; i++) begin
            code = $fscanf(fd, "%h", val);
            if (code != 1) begin
                $display("A stim record is short or holds a value that is not hex");
                other_errors++;
            end
            v[i] = val;
        end
    endtask

    task automatic load_stim();
        int                 fd;
        int                 code;
        int                 stall;
        logic [7:0]         tag;
        logic [8*200-1:0]   line;
        vec_t               v;
        vec_t               e;
        fd = $fopen("tb/llm_int_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stim file tb/llm_int_stim.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "#") begin
                code = $fgets(line, fd);  // Rest of a comment line.
            end else if (tag == "W") begin
                read_vec(fd, v);
                rec_is_input.push_back(1'b0);
                rec_vec.push_back(v);
                rec_stall.push_back(0);
                rec_exp.push_back('0);
            end else if (tag == "X") begin
                read_vec(fd, v);
                code = $fscanf(fd, "%d", stall);
                read_vec(fd, e);
                rec_is_input.push_back(1'b1);
                rec_vec.push_back(v);
                rec_stall.push_back(stall);
                rec_exp.push_back(e);
                n_vectors++;
            end else begin
                $display("Unknown record tag %s in the stim file", tag);
                other_errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("FAIL %s: expected %h, got %h", name, exp, got);
            value_errors++;
        end
    endtask

    task automatic check_vec(input vec_t got, input vec_t exp);
        for (int i = 0; i < N; i++) begin
            assert (got[i] === exp[i]) else begin
                $display("FAIL out_data[%0d]: expected %h, got %h", i, exp[i], got[i]);
                value_errors++;
            end
        end
    endtask

    // Idle cycles in ST_IDLE, inputs only open once a whole matrix is in.
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            check_bit("weight_ready", weight_ready, 1'b1);
            check_bit("in_ready", in_ready, matrix_whole);
            check_bit("out_valid", out_valid, 1'b0);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_weight(input vec_t row);
        logic fire;
        weight_row   = row;
        weight_valid = 1'b1;
        fire         = 1'b0;
        while (!fire) begin
            @(negedge clk);
            fire = weight_ready;
            @(posedge clk);
            #1;
        end
        weight_valid = 1'b0;
        if (w_idx == N - 1) begin
            matrix_whole = 1'b1;
            w_idx        = 0;
        end else begin
            if (w_idx == 0) begin
                matrix_whole = 1'b0;  // First row of a new matrix.
            end
            w_idx++;
        end
    endtask

    task automatic run_vector(input vec_t x, input int stall, input vec_t exp);
        logic fire;
        int   cycles;
        in_data   = x;
        in_valid  = 1'b1;
        out_ready = (stall == 0);
        fire      = 1'b0;
        while (!fire) begin
            @(negedge clk);
            fire = in_ready;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        cycles   = 0;
        @(negedge clk);
        while (!out_valid) begin
            check_bit("in_ready", in_ready, 1'b0);
            check_bit("weight_ready", weight_ready, 1'b0);
            @(posedge clk);
            #1;
            cycles++;
            @(negedge clk);
        end
        assert (cycles == N) else begin
            $display("out_valid came %0d cycles after the input handshake, not %0d",
                     cycles, N);
            other_errors++;
        end
        check_vec(out_data, exp);
        check_bit("in_ready", in_ready, 1'b0);
        check_bit("weight_ready", weight_ready, 1'b0);
        for (int s = 1; s < stall; s++) begin
            @(posedge clk);
            #1;
            @(negedge clk);
            check_bit("out_valid", out_valid, 1'b1);
            check_vec(out_data, exp);  // Must hold under back-pressure.
            check_bit("in_ready", in_ready, 1'b0);
            check_bit("weight_ready", weight_ready, 1'b0);
        end
        @(posedge clk);
        #1;
        if (stall > 0) begin
            out_ready = 1'b1;
            @(posedge clk);
            #1;
        end
        out_ready = 1'b0;
    endtask

    initial begin
        wait (stim_loaded);
        repeat (200 * (n_vectors + 1)) @(posedge clk);
        other_errors++;
        $display("Timeout after %0d cycles, the DUT stopped responding",
                 200 * (n_vectors + 1));
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        weight_valid = 1'b0;
        weight_row   = '0;
        in_valid     = 1'b0;
        in_data      = '0;
        out_ready    = 1'b0;
        value_errors = 0;
        other_errors = 0;
        n_vectors    = 0;
        w_idx        = 0;
        matrix_whole = 1'b0;
        stim_loaded  = 1'b0;
        rng          = 32'h2b72_79ff;
        load_stim();
        if (n_vectors == 0) begin
            $display("The stim file holds no input vectors");
            other_errors++;
        end
        stim_loaded = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        @(posedge clk);
        #1;
        idle_cycles(2);  // No weights yet, so in_ready stays low.
        for (int r = 0; r < rec_is_input.size(); r++) begin
            rng = xorshift32(rng);
            idle_cycles(int'(rng[1:0]));
            if (rec_is_input[r]) begin
                run_vector(rec_vec[r], rec_stall[r], rec_exp[r]);
            end else begin
                send_weight(rec_vec[r]);
            end
        end
        idle_cycles(2);
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- src/llm_int_linear.sv
`timescale 1ns/1ps

module llm_int_linear #(
    parameter  int N          = 4,
    parameter  int HIGH_SLOTS = 2,
    parameter  int THRESHOLD  = 6,
    parameter  int FRAC_BITS  = 8,
    localparam int RW         = (N > 1) ? $clog2(N) : 1
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       weight_valid,
    output logic                       weight_ready,
    input  llm_int_pkg::act_t [N-1:0]  weight_row,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  llm_int_pkg::act_t [N-1:0]  in_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output llm_int_pkg::act_t [N-1:0]  out_data
);

    logic                       weights_full;
    logic                       wr_en;
    logic [RW-1:0]              wr_row;
    logic                       capture;
    logic                       busy;
    logic [RW-1:0]              row_sel;
    logic                       res_wr;
    logic [RW-1:0]              res_row;
    llm_int_pkg::act_t  [N-1:0] w_row;
    llm_int_pkg::qact_t [N-1:0] wq_row;
    llm_int_pkg::act_t  [N-1:0] hi_vec;
    llm_int_pkg::qact_t [N-1:0] lo_vec;
    llm_int_pkg::act_t          y;

    linear_ctrl #(.N(N)) u_ctrl (
        .clk, .arst_n, .weight_valid, .weight_ready, .in_valid, .in_ready,
        .out_valid, .out_ready, .weights_full, .wr_en, .wr_row, .capture,
        .busy, .row_sel, .res_wr, .res_row
    );

    outlier_scatter #(.N(N), .HIGH_SLOTS(HIGH_SLOTS), .THRESHOLD(THRESHOLD)) u_scatter (
        .clk, .arst_n, .capture, .in_data, .hi_vec, .lo_vec
    );

    weight_store #(.N(N)) u_wstore (
        .clk, .arst_n, .wr_en, .wr_row, .weight_row, .row_sel, .busy,
        .w_row, .wq_row, .weights_full
    );

    dual_precision_dot #(.N(N), .FRAC_BITS(FRAC_BITS)) u_dot (
        .w_row, .wq_row, .hi_vec, .lo_vec, .y
    );

    result_gather #(.N(N)) u_gather (
        .clk, .arst_n, .res_wr, .res_row, .y, .out_valid, .out_ready, .out_data
    );

endmodule

//--- src/linear_ctrl.sv
`timescale 1ns/1ps

module linear_ctrl #(
    parameter  int N  = 4,
    localparam int RW = (N > 1) ? $clog2(N) : 1
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          weight_valid,
    output logic          weight_ready,
    input  logic          in_valid,
    output logic          in_ready,
    output logic          out_valid,
    input  logic          out_ready,
    input  logic          weights_full,
    output logic          wr_en,
    output logic [RW-1:0] wr_row,
    output logic          capture,
    output logic          busy,
    output logic [RW-1:0] row_sel,
    output logic          res_wr,
    output logic [RW-1:0] res_row
);

    llm_int_pkg::ctrl_state_t state;
    llm_int_pkg::ctrl_state_t state_nxt;

    logic [RW-1:0] wr_cnt;    // Next weight row to load.
    logic [RW-1:0] comp_row;  // Row being computed.
    logic          last_row;

    assign weight_ready = (state == llm_int_pkg::ST_IDLE);
    // A pending weight beat goes first, so a compute pass never sees a mixed matrix.
    assign in_ready  = (state == llm_int_pkg::ST_IDLE) && weights_full && !weight_valid;
    assign out_valid = (state == llm_int_pkg::ST_OUTPUT);
    assign busy      = (state == llm_int_pkg::ST_COMPUTE);

    assign wr_en    = weight_valid && weight_ready;
    assign wr_row   = wr_cnt;
    assign capture  = in_valid && in_ready;
    assign row_sel  = comp_row;
    assign res_wr   = busy;
    assign res_row  = comp_row;
    assign last_row = (comp_row == RW'(N - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            llm_int_pkg::ST_IDLE: begin
                if (capture) begin
                    state_nxt = llm_int_pkg::ST_COMPUTE;
                end
            end
            llm_int_pkg::ST_COMPUTE: begin
                if (last_row) begin
                    state_nxt = llm_int_pkg::ST_OUTPUT;  // N cycles after capture.
                end
            end
            llm_int_pkg::ST_OUTPUT: begin
                if (out_ready) begin
                    state_nxt = llm_int_pkg::ST_IDLE;
                end
            end
            default: state_nxt = llm_int_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= llm_int_pkg::ST_IDLE;
            wr_cnt   <= '0;
            comp_row <= '0;
        end else begin
            state <= state_nxt;
            if (wr_en) begin
                wr_cnt <= (wr_cnt == RW'(N - 1)) ? '0 : wr_cnt + 1'b1;  // Wraps per matrix.
            end
            if (capture) begin
                comp_row <= '0;
            end else if (busy) begin
                comp_row <= last_row ? '0 : comp_row + 1'b1;
            end
        end
    end

    // One row per cycle, so out_valid is up N cycles after the input beat.
    latency_a: assert property (@(posedge clk) disable iff (!arst_n)
        capture |-> ##(N + 1) out_valid);

endmodule

//--- src/result_gather.sv
`timescale 1ns/1ps

module result_gather #(
    parameter  int N  = 4,
    localparam int RW = (N > 1) ? $clog2(N) : 1
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       res_wr,
    input  logic [RW-1:0]              res_row,
    input  llm_int_pkg::act_t          y,
    input  logic                       out_valid,
    input  logic                       out_ready,
    output llm_int_pkg::act_t [N-1:0]  out_data
);

    // One element per compute cycle, held until overwritten.
    always_ff @(posedge clk) begin
        if (res_wr) begin
            out_data[res_row] <= y;
        end
    end

    // A pending output beat must not see its data change.
    stable_out_a: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> !res_wr);

endmodule

//--- src/dual_precision_dot.sv
`timescale 1ns/1ps

module dual_precision_dot #(
    parameter int N         = 4,
    parameter int FRAC_BITS = 8
) (
    input  llm_int_pkg::act_t  [N-1:0] w_row,
    input  llm_int_pkg::qact_t [N-1:0] wq_row,
    input  llm_int_pkg::act_t  [N-1:0] hi_vec,
    input  llm_int_pkg::qact_t [N-1:0] lo_vec,
    output llm_int_pkg::act_t          y
);

    localparam llm_int_pkg::acc_t SAT_MAX =
        llm_int_pkg::acc_t'((2 ** (llm_int_pkg::ORIG_W - 1)) - 1);
    localparam llm_int_pkg::acc_t SAT_MIN =
        llm_int_pkg::acc_t'(-(2 ** (llm_int_pkg::ORIG_W - 1)));

    llm_int_pkg::acc_t hi_acc;   // Outlier products.
    llm_int_pkg::acc_t lo_acc;   // Quantized products.
    llm_int_pkg::acc_t sum;
    llm_int_pkg::acc_t scaled;

    always_comb begin
        hi_acc = '0;
        lo_acc = '0;
        for (int i = 0; i < N; i++) begin
            hi_acc += llm_int_pkg::acc_t'(w_row[i]) * llm_int_pkg::acc_t'(hi_vec[i]);
            lo_acc += llm_int_pkg::acc_t'(wq_row[i]) * llm_int_pkg::acc_t'(lo_vec[i]);
        end
    end

    // Both operands lost QSHIFT bits, so the product goes back up twice that.
    assign sum    = hi_acc + (lo_acc <<< (2 * llm_int_pkg::QSHIFT));
    assign scaled = sum >>> FRAC_BITS;  // Plain truncation.

    always_comb begin
        if (scaled > SAT_MAX) begin
            y = llm_int_pkg::act_t'(SAT_MAX);  // Clips to 16'h7fff.
        end else if (scaled < SAT_MIN) begin
            y = llm_int_pkg::act_t'(SAT_MIN);  // Clips to 16'h8000.
        end else begin
            y = llm_int_pkg::act_t'(scaled);
        end
    end

endmodule

//--- src/weight_store.sv
`timescale 1ns/1ps

module weight_store #(
    parameter  int N  = 4,
    localparam int RW = (N > 1) ? $clog2(N) : 1
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          wr_en,
    input  logic [RW-1:0]                 wr_row,
    input  llm_int_pkg::act_t  [N-1:0]    weight_row,
    input  logic [RW-1:0]                 row_sel,
    input  logic                          busy,
    output llm_int_pkg::act_t  [N-1:0]    w_row,
    output llm_int_pkg::qact_t [N-1:0]    wq_row,
    output logic                          weights_full
);

    llm_int_pkg::act_t  [N-1:0] w_mem  [N];  // Full-precision rows.
    llm_int_pkg::qact_t [N-1:0] wq_mem [N];  // Quantized copies.

    // The quantized copy is made once per load, not per use.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            w_mem[wr_row] <= weight_row;
            for (int i = 0; i < N; i++) begin
                wq_mem[wr_row][i] <= llm_int_pkg::quantize(weight_row[i]);
            end
        end
    end

    // Row 0 starts a new matrix, so the old one is no longer whole.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            weights_full <= 1'b0;
        end else if (wr_en) begin
            if (wr_row == RW'(N - 1)) begin
                weights_full <= 1'b1;
            end else if (wr_row == '0) begin
                weights_full <= 1'b0;
            end
        end
    end

    assign w_row  = w_mem[row_sel];   // Combinational read.
    assign wq_row = wq_mem[row_sel];

    // Rows must not change under a running compute pass.
    no_wr_busy_a: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> !busy);

endmodule

//--- src/outlier_scatter.sv
`timescale 1ns/1ps

module outlier_scatter #(
    parameter int N          = 4,
    parameter int HIGH_SLOTS = 2,
    parameter int THRESHOLD  = 6
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          capture,
    input  llm_int_pkg::act_t  [N-1:0]    in_data,
    output llm_int_pkg::act_t  [N-1:0]    hi_vec,
    output llm_int_pkg::qact_t [N-1:0]    lo_vec
);

    llm_int_pkg::act_t  [N-1:0] hi_nxt;
    llm_int_pkg::qact_t [N-1:0] lo_nxt;

    // Lowest index wins a free high-precision slot.
    always_comb begin
        int cnt;
        int mag;
        cnt    = 0;
        hi_nxt = '0;
        lo_nxt = '0;
        for (int i = 0; i < N; i++) begin
            mag = int'(in_data[i]);
            if (mag < 0) begin
                mag = -mag;  // No overflow, int is wider than act_t.
            end
            if (mag >= THRESHOLD && cnt < HIGH_SLOTS) begin
                hi_nxt[i] = in_data[i];
                cnt++;
            end else begin
                lo_nxt[i] = llm_int_pkg::quantize(in_data[i]);
            end
        end
    end

    // Operand sets stay put for the whole compute pass.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi_vec <= '0;
            lo_vec <= '0;
        end else if (capture) begin
            hi_vec <= hi_nxt;
            lo_vec <= lo_nxt;
        end
    end

endmodule

//--- src/llm_int_pkg.sv
package llm_int_pkg;

    // Element widths.
    localparam int ORIG_W = 16;  // Full-precision activations and weights.
    localparam int RED_W  = 8;   // Quantized activations and weights.
    localparam int QSHIFT = ORIG_W - RED_W;

    // Holds N up to 16 with room for the scaled reduced sum.
    localparam int ACC_W  = 40;

    typedef logic signed [ORIG_W-1:0] act_t;
    typedef logic signed [RED_W-1:0]  qact_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    typedef enum logic [1:0] {
        ST_IDLE,     // Weight loading and input acceptance.
        ST_COMPUTE,  // One output row per cycle.
        ST_OUTPUT    // Result held for the output beat.
    } ctrl_state_t;

    // Keeps the upper RED_W bits, truncating toward minus infinity.
    function automatic qact_t quantize(input act_t v);
        act_t shifted;
        shifted = v >>> QSHIFT;
        return qact_t'(shifted);
    endfunction

endpackage
